//--- logic/cpu_pkg.sv
`default_nettype none

package cpu_pkg;

    localparam int WORD_W     = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [WORD_W-1:0]     word_t;
    typedef logic [2*WORD_W-1:0]   dword_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // return address of jump-and-link, past the delay slot
    localparam word_t LINK_OFFSET = 32'd8;

    // decoded operations
    typedef enum logic [5:0] {
        OP_NOP,
        OP_AND, OP_ANDI, OP_OR, OP_ORI, OP_XOR, OP_XORI, OP_NOR,
        OP_SLL, OP_SLLV, OP_SRL, OP_SRLV, OP_SRA, OP_SRAV,
        OP_LUI, OP_MOVN, OP_MOVZ,
        OP_MFHI, OP_MFLO, OP_MTHI, OP_MTLO,
        OP_ADD, OP_ADDI, OP_ADDU, OP_ADDIU, OP_SUB, OP_SUBU,
        OP_SLT, OP_SLTI, OP_SLTU, OP_SLTIU,
        OP_MUL, OP_MULT, OP_MULTU,
        OP_JAL, OP_JALR, OP_BLTZAL, OP_BGEZAL,
        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW,
        OP_SB, OP_SH, OP_SW
    } oper_t;

    // one instruction as handed over by decode
    typedef struct packed {
        oper_t     oper;
        word_t     pc;
        word_t     reg1;
        word_t     reg2;
        logic      wreg_write;
        reg_addr_t wreg_addr;
    } issue_t;

    // execute result, carried unchanged through EX/MEM and MEM/WB
    typedef struct packed {
        oper_t     oper;
        logic      wreg_write;
        reg_addr_t wreg_addr;
        word_t     wreg_data;
        logic      whilo;
        word_t     hi;
        word_t     lo;
        word_t     mem_addr;
        word_t     mem_data;
    } ex_result_t;

    // HI/LO write still in flight
    typedef struct packed {
        logic  whilo;
        word_t hi;
        word_t lo;
    } hilo_fwd_t;

endpackage

`default_nettype wire

//--- logic/ex_stage.sv
`default_nettype none

module ex_stage (
    input  wire cpu_pkg::issue_t    issue_i,
    input  wire cpu_pkg::word_t     hi_i,
    input  wire cpu_pkg::word_t     lo_i,
    input  wire cpu_pkg::hilo_fwd_t mem_fwd_i,
    input  wire cpu_pkg::hilo_fwd_t wb_fwd_i,
    output cpu_pkg::ex_result_t     result_o
);
    import cpu_pkg::*;

    oper_t oper;
    word_t reg1;
    word_t reg2;

    assign oper = issue_i.oper;
    assign reg1 = issue_i.reg1;
    assign reg2 = issue_i.reg2;

    // current HI/LO, youngest in-flight write wins
    word_t hi;
    word_t lo;

    always_comb begin
        if (mem_fwd_i.whilo) begin
            hi = mem_fwd_i.hi;
            lo = mem_fwd_i.lo;
        end else if (wb_fwd_i.whilo) begin
            hi = wb_fwd_i.hi;
            lo = wb_fwd_i.lo;
        end else begin
            hi = hi_i;
            lo = lo_i;
        end
    end

    // shared adder and subtractor
    word_t add_res;
    word_t sub_res;

    assign add_res = reg1 + reg2;
    assign sub_res = reg1 - reg2;

    // sign bits differ -> reg1 sign decides, else sign of the difference
    logic signed_lt;
    logic unsigned_lt;

    assign signed_lt   = (reg1[31] != reg2[31]) ? reg1[31] : sub_res[31];
    assign unsigned_lt = (reg1 < reg2);

    // multiply on magnitudes, sign applied afterwards
    logic   mul_signed;
    logic   mul_neg;
    word_t  abs_reg1;
    word_t  abs_reg2;
    dword_t mul_abs;
    dword_t mul_res;

    assign mul_signed = (oper != OP_MULTU);
    assign mul_neg    = mul_signed && (reg1[31] ^ reg2[31]);
    assign abs_reg1   = (mul_signed && reg1[31]) ? -reg1 : reg1;
    assign abs_reg2   = (mul_signed && reg2[31]) ? -reg2 : reg2;
    assign mul_abs    = dword_t'(abs_reg1) * dword_t'(abs_reg2);
    assign mul_res    = mul_neg ? -mul_abs : mul_abs;

    word_t link_addr;

    assign link_addr = issue_i.pc + LINK_OFFSET;

    always_comb begin
        result_o            = '0;
        result_o.oper       = oper;
        result_o.wreg_write = issue_i.wreg_write;
        result_o.wreg_addr  = issue_i.wreg_addr;
        result_o.hi         = hi;
        result_o.lo         = lo;

        // HI/LO writers never touch the register file
        if (oper inside {OP_MULT, OP_MULTU, OP_MTHI, OP_MTLO}) begin
            result_o.whilo      = 1'b1;
            result_o.wreg_write = 1'b0;
        end

        case (oper)
            OP_AND, OP_ANDI: result_o.wreg_data = reg1 & reg2;
            OP_OR, OP_ORI:   result_o.wreg_data = reg1 | reg2;
            OP_XOR, OP_XORI: result_o.wreg_data = reg1 ^ reg2;
            OP_NOR:          result_o.wreg_data = ~(reg1 | reg2);
            OP_SLL, OP_SLLV: result_o.wreg_data = reg2 << reg1[4:0];
            OP_SRL, OP_SRLV: result_o.wreg_data = reg2 >> reg1[4:0];
            OP_SRA, OP_SRAV: result_o.wreg_data = word_t'($signed(reg2) >>> reg1[4:0]);
            OP_LUI:          result_o.wreg_data = {reg2[15:0], 16'h0000};
            OP_MOVN: begin
                result_o.wreg_write = (reg2 != '0);
                result_o.wreg_data  = (reg2 != '0) ? reg1 : '0;
            end
            OP_MOVZ: begin
                result_o.wreg_write = (reg2 == '0);
                result_o.wreg_data  = (reg2 == '0) ? reg1 : '0;
            end
            OP_MFHI: result_o.wreg_data = hi;
            OP_MFLO: result_o.wreg_data = lo;
            // only one half is replaced
            OP_MTHI: result_o.hi = reg1;
            OP_MTLO: result_o.lo = reg1;
            // no overflow trap, ADD behaves like ADDU
            OP_ADD, OP_ADDI, OP_ADDU, OP_ADDIU: result_o.wreg_data = add_res;
            OP_SUB, OP_SUBU:   result_o.wreg_data = sub_res;
            OP_SLT, OP_SLTI:   result_o.wreg_data = word_t'(signed_lt);
            OP_SLTU, OP_SLTIU: result_o.wreg_data = word_t'(unsigned_lt);
            OP_MUL:            result_o.wreg_data = mul_res[31:0];
            OP_MULT, OP_MULTU: {result_o.hi, result_o.lo} = mul_res;
            OP_JAL, OP_JALR, OP_BLTZAL, OP_BGEZAL: begin
                result_o.wreg_write = 1'b1;
                result_o.wreg_data  = link_addr;
            end
            OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: result_o.mem_addr = add_res;
            OP_SB, OP_SH, OP_SW: begin
                result_o.mem_addr = reg1;
                result_o.mem_data = reg2;
            end
            // NOP keeps the defaults
            default: ;
        endcase
    end

endmodule

`default_nettype wire

//--- logic/exec_pipe.sv
`default_nettype none

module exec_pipe (
    input  wire logic                clk_i,
    input  wire logic                rst_n_i,
    input  wire logic                valid_i,
    input  wire cpu_pkg::ex_result_t result_i,
    output cpu_pkg::hilo_fwd_t       mem_fwd_o,
    output cpu_pkg::hilo_fwd_t       wb_fwd_o,
    output logic                     wb_valid_o,
    output cpu_pkg::ex_result_t      wb_o
);
    import cpu_pkg::*;

    logic       mem_valid_q;
    logic       wb_valid_q;
    ex_result_t mem_q;
    ex_result_t wb_q;

    // stage valid bits
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            mem_valid_q <= 1'b0;
            wb_valid_q  <= 1'b0;
        end else begin
            mem_valid_q <= valid_i;
            wb_valid_q  <= mem_valid_q;
        end
    end

    // payload, qualified by the valid bits above
    always_ff @(posedge clk_i) begin
        mem_q <= result_i;
        wb_q  <= mem_q;
    end

    // forwarding views, bubbles never write HI/LO
    assign mem_fwd_o.whilo = mem_valid_q & mem_q.whilo;
    assign mem_fwd_o.hi    = mem_q.hi;
    assign mem_fwd_o.lo    = mem_q.lo;

    assign wb_fwd_o.whilo = wb_valid_q & wb_q.whilo;
    assign wb_fwd_o.hi    = wb_q.hi;
    assign wb_fwd_o.lo    = wb_q.lo;

    assign wb_valid_o = wb_valid_q;
    assign wb_o       = wb_q;

endmodule

`default_nettype wire

//--- logic/hilo_reg.sv
`default_nettype none

module hilo_reg (
    input  wire logic               clk_i,
    input  wire logic               rst_n_i,
    input  wire cpu_pkg::hilo_fwd_t wb_fwd_i,
    output cpu_pkg::word_t          hi_o,
    output cpu_pkg::word_t          lo_o
);

    // architectural HI/LO, loaded as a pair from writeback
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            hi_o <= '0;
            lo_o <= '0;
        end else if (wb_fwd_i.whilo) begin
            hi_o <= wb_fwd_i.hi;
            lo_o <= wb_fwd_i.lo;
        end
    end

endmodule

`default_nettype wire

//--- logic/ex_unit_top.sv
`default_nettype none

module ex_unit_top (
    input  wire logic            clk_i,
    input  wire logic            rst_n_i,
    input  wire logic            issue_valid_i,
    input  wire cpu_pkg::issue_t issue_i,
    output logic                 wb_valid_o,
    output cpu_pkg::ex_result_t  wb_o
);
    import cpu_pkg::*;

    ex_result_t ex_result;
    hilo_fwd_t  mem_fwd;
    hilo_fwd_t  wb_fwd;
    word_t      hi;
    word_t      lo;

    ex_stage u_ex_stage (
        .issue_i   (issue_i),
        .hi_i      (hi),
        .lo_i      (lo),
        .mem_fwd_i (mem_fwd),
        .wb_fwd_i  (wb_fwd),
        .result_o  (ex_result)
    );

    // EX/MEM and MEM/WB
    exec_pipe u_exec_pipe (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .valid_i    (issue_valid_i),
        .result_i   (ex_result),
        .mem_fwd_o  (mem_fwd),
        .wb_fwd_o   (wb_fwd),
        .wb_valid_o (wb_valid_o),
        .wb_o       (wb_o)
    );

    hilo_reg u_hilo_reg (
        .clk_i    (clk_i),
        .rst_n_i  (rst_n_i),
        .wb_fwd_i (wb_fwd),
        .hi_o     (hi),
        .lo_o     (lo)
    );

endmodule

`default_nettype wire

//--- sim/ex_unit_assertions.sv
`default_nettype none

module ex_unit_assertions (
    input wire logic                clk_i,
    input wire logic                rst_n_i,
    input wire logic                issue_valid_i,
    input wire logic                wb_valid_o,
    input wire cpu_pkg::ex_result_t wb_o
);

    int fail_count = 0;

    // fixed latency once both stages have left reset
    a_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $past(rst_n_i) && $past(rst_n_i, 2) |-> wb_valid_o == $past(issue_valid_i, 2))
        else begin
            $error("writeback valid does not follow issue by two cycles");
            fail_count++;
        end

    a_reset_clears: assert property (@(posedge clk_i) !rst_n_i |=> !wb_valid_o)
        else begin
            $error("writeback valid set in the cycle after reset");
            fail_count++;
        end

    // HI/LO writers never target the register file
    a_one_target: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        wb_valid_o |-> !(wb_o.whilo && wb_o.wreg_write))
        else begin
            $error("writeback writes both HI/LO and a register");
            fail_count++;
        end

endmodule

bind ex_unit_top ex_unit_assertions u_assertions (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .issue_valid_i (issue_valid_i),
    .wb_valid_o    (wb_valid_o),
    .wb_o          (wb_o)
);

`default_nettype wire

//--- sim/ex_unit_model.svh
`ifndef EX_UNIT_MODEL_SVH
`define EX_UNIT_MODEL_SVH

// HI/LO after every instruction issued so far
word_t model_hi = '0;
word_t model_lo = '0;

function automatic ex_result_t expected_result(input issue_t ins);
    ex_result_t r;
    word_t      a;
    word_t      b;
    dword_t     sprod;
    dword_t     uprod;
    a     = ins.reg1;
    b     = ins.reg2;
    // low 64 bits of the extended operands give the full product
    sprod = {{32{a[31]}}, a} * {{32{b[31]}}, b};
    uprod = {32'h0, a} * {32'h0, b};
    r            = '0;
    r.oper       = ins.oper;
    r.wreg_write = ins.wreg_write;
    r.wreg_addr  = ins.wreg_addr;
    r.hi         = model_hi;
    r.lo         = model_lo;
    case (ins.oper)
        OP_AND, OP_ANDI:   r.wreg_data = a & b;
        OP_OR, OP_ORI:     r.wreg_data = a | b;
        OP_XOR, OP_XORI:   r.wreg_data = a ^ b;
        OP_NOR:            r.wreg_data = ~(a | b);
        OP_SLL, OP_SLLV:   r.wreg_data = b << a[4:0];
        OP_SRL, OP_SRLV:   r.wreg_data = b >> a[4:0];
        OP_SRA, OP_SRAV:   r.wreg_data = $signed(b) >>> a[4:0];
        OP_LUI:            r.wreg_data = {b[15:0], 16'h0000};
        OP_MOVN:           {r.wreg_write, r.wreg_data} = (b != '0) ? {1'b1, a} : 33'h0;
        OP_MOVZ:           {r.wreg_write, r.wreg_data} = (b == '0) ? {1'b1, a} : 33'h0;
        OP_MFHI:           r.wreg_data = model_hi;
        OP_MFLO:           r.wreg_data = model_lo;
        OP_MTHI:           {r.whilo, r.wreg_write, r.hi} = {2'b10, a};
        OP_MTLO:           {r.whilo, r.wreg_write, r.lo} = {2'b10, a};
        OP_ADD, OP_ADDI, OP_ADDU, OP_ADDIU: r.wreg_data = a + b;
        OP_SUB, OP_SUBU:   r.wreg_data = a - b;
        OP_SLT, OP_SLTI:   r.wreg_data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        OP_SLTU, OP_SLTIU: r.wreg_data = (a < b) ? 32'd1 : 32'd0;
        OP_MUL:            r.wreg_data = sprod[31:0];
        OP_MULT:           {r.whilo, r.wreg_write, r.hi, r.lo} = {2'b10, sprod};
        OP_MULTU:          {r.whilo, r.wreg_write, r.hi, r.lo} = {2'b10, uprod};
        OP_JAL, OP_JALR, OP_BLTZAL, OP_BGEZAL:
            {r.wreg_write, r.wreg_data} = {1'b1, ins.pc + 32'd8};
        OP_LB, OP_LBU, OP_LH, OP_LHU, OP_LW: r.mem_addr = a + b;
        OP_SB, OP_SH, OP_SW: {r.mem_addr, r.mem_data} = {a, b};
        default: ;
    endcase
    return r;
endfunction

// a HI/LO writer is seen by everything issued after it
task automatic model_commit(input ex_result_t r);
    if (r.whilo) begin
        model_hi = r.hi;
        model_lo = r.lo;
    end
endtask

`endif

//--- sim/ex_unit_tb.sv
`default_nettype none

module ex_unit_tb;
    import cpu_pkg::*;

    localparam int RESET_CYCLES = 3;
    localparam int N_RANDOM     = 400;
    // four HI/LO bursts of 12 cycles each
    localparam int N_DIRECTED   = 48;
    localparam int LATENCY      = 2;
    localparam int MAX_CYCLES   = RESET_CYCLES + N_RANDOM + N_DIRECTED + 50;

    logic       clk_i = 1'b0;
    logic       rst_n_i;
    logic       issue_valid_i;
    issue_t     issue_i;
    logic       wb_valid_o;
    ex_result_t wb_o;

    integer     seed;
    int         cycle;
    int         elapsed = 0;
    int         value_errors;
    int         other_errors;
    int         assertion_errors;
    ex_result_t exp_q[$];
    int         due_q[$];

    `include "ex_unit_model.svh"

    ex_unit_top u_dut (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .issue_valid_i (issue_valid_i),
        .issue_i       (issue_i),
        .wb_valid_o    (wb_valid_o),
        .wb_o          (wb_o)
    );

    always #5 clk_i = ~clk_i;

    always @(posedge clk_i) begin
        elapsed <= elapsed + 1;
        if (elapsed >= MAX_CYCLES) begin
            $display("Error: run did not finish within %0d cycles", MAX_CYCLES);
            $display("** FAIL **");
            $finish;
        end
    end

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] want);
        if (got !== want) begin
            value_errors++;
            $display("Fail at %0t: %s = %0h, expected %0h", $time, name, got, want);
        end
    endtask

    task automatic check_output();
        ex_result_t want;
        int         due;
        if (wb_valid_o === 1'b1 && exp_q.size() == 0) begin
            other_errors++;
            $display("Error at %0t: valid writeback with nothing outstanding", $time);
        end else if (wb_valid_o === 1'b1) begin
            want = exp_q.pop_front();
            due  = due_q.pop_front();
            compare("writeback cycle", cycle, due);
            compare("wb_o.oper", wb_o.oper, want.oper);
            compare("wb_o.wreg_write", wb_o.wreg_write, want.wreg_write);
            compare("wb_o.wreg_addr", wb_o.wreg_addr, want.wreg_addr);
            compare("wb_o.wreg_data", wb_o.wreg_data, want.wreg_data);
            compare("wb_o.whilo", wb_o.whilo, want.whilo);
            compare("wb_o.hi:lo", {wb_o.hi, wb_o.lo}, {want.hi, want.lo});
            compare("wb_o.mem_addr:data", {wb_o.mem_addr, wb_o.mem_data},
                    {want.mem_addr, want.mem_data});
        end else begin
            compare("wb_valid_o", wb_valid_o, 1'b0);
            if (due_q.size() != 0 && due_q[0] == cycle) begin
                other_errors++;
                $display("Error at %0t: issued instruction missed its writeback cycle", $time);
            end
        end
    endtask

    task automatic next_cycle();
        @(posedge clk_i);
        #1;
        cycle++;
        check_output();
    endtask

    task automatic drive(input logic valid, input issue_t ins);
        ex_result_t want;
        issue_valid_i = valid;
        issue_i       = ins;
        if (valid) begin
            want = expected_result(ins);
            model_commit(want);
            exp_q.push_back(want);
            due_q.push_back(cycle + LATENCY);
        end
        next_cycle();
    endtask

    function automatic issue_t random_issue();
        issue_t ins;
        int     idx;
        idx            = $unsigned($random(seed)) % (int'(OP_SW) + 1);
        ins.oper       = oper_t'(idx[5:0]);
        ins.pc         = word_t'($random(seed));
        ins.reg1       = word_t'($random(seed));
        ins.reg2       = word_t'($random(seed));
        ins.wreg_write = 1'($random(seed));
        ins.wreg_addr  = reg_addr_t'($random(seed));
        // zero reg2 now and then so MOVN and MOVZ go both ways
        if (($random(seed) & 7) == 0) begin
            ins.reg2 = '0;
        end
        return ins;
    endfunction

    function automatic issue_t make_issue(input oper_t op);
        issue_t ins;
        ins      = random_issue();
        ins.oper = op;
        return ins;
    endfunction

    task automatic hilo_burst(input oper_t writer);
        // read straight after: MEM forwarding, then WB forwarding
        drive(1'b1, make_issue(writer));
        drive(1'b1, make_issue(OP_MFLO));
        drive(1'b1, make_issue(OP_MFHI));
        drive(1'b1, make_issue(writer));
        drive(1'b0, random_issue());
        drive(1'b1, make_issue(OP_MFHI));
        // long after, read back from the register
        drive(1'b1, make_issue(writer));
        repeat (3) drive(1'b0, random_issue());
        drive(1'b1, make_issue(OP_MFLO));
        drive(1'b1, make_issue(OP_MFHI));
    endtask

    initial begin
        seed          = 11165;
        cycle         = 0;
        value_errors  = 0;
        other_errors  = 0;
        rst_n_i       = 1'b0;
        issue_valid_i = 1'b0;
        issue_i       = '0;
        repeat (RESET_CYCLES) next_cycle();
        rst_n_i = 1'b1;
        repeat (N_RANDOM) drive(($random(seed) & 3) != 0, random_issue());
        hilo_burst(OP_MULT);
        hilo_burst(OP_MULTU);
        hilo_burst(OP_MTHI);
        hilo_burst(OP_MTLO);
        // last issue is due after LATENCY more edges, then a few idle cycles
        repeat (LATENCY + 2) drive(1'b0, '0);
        if (exp_q.size() != 0) begin
            other_errors++;
            $display("Error: %0d instructions still outstanding at the end", exp_q.size());
        end
        assertion_errors = u_dut.u_assertions.fail_count;
        $display("value errors %0d, other errors %0d, assertion errors %0d",
                 value_errors, other_errors, assertion_errors);
        if (value_errors == 0 && other_errors == 0 && assertion_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+sim
logic/cpu_pkg.sv
logic/ex_stage.sv
logic/exec_pipe.sv
logic/hilo_reg.sv
logic/ex_unit_top.sv
sim/ex_unit_assertions.sv
sim/ex_unit_tb.sv

//--- Bender.yml
package:
  name: ex_unit

sources:
  - files:
      - logic/cpu_pkg.sv
      - logic/ex_stage.sv
      - logic/exec_pipe.sv
      - logic/hilo_reg.sv
      - logic/ex_unit_top.sv
  - target: simulation
    include_dirs:
      - sim
    files:
      - sim/ex_unit_assertions.sv
      - sim/ex_unit_tb.sv
